// ==== test/arr_vectors.txt ====
// One hex byte per entry, several per line
// Config out_ch in_ch width height, then 54 weights, then 72 activations
03 02 06 06
// Weights, one kernel slice per line (out channel, in channel)
01 02 03 04 05 06 07 08 09
0a 0b 0c 0d 0e 0f 10 11 12
13 14 15 16 17 18 19 1a 1b
1c 1d 1e 1f 20 21 22 23 24
25 26 27 28 29 2a 2b 2c 2d
2e 2f 30 31 32 33 34 35 36
// Activations, one image row per line, channel 0 then channel 1
80 81 82 83 84 85
86 87 88 89 8a 8b
8c 8d 8e 8f 90 91
92 93 94 95 96 97
98 99 9a 9b 9c 9d
9e 9f a0 a1 a2 a3
a4 a5 a6 a7 a8 a9
aa ab ac ad ae af
b0 b1 b2 b3 b4 b5
b6 b7 b8 b9 ba bb
bc bd be bf c0 c1
c2 c3 c4 c5 c6 c7

// ==== all.f ====
+incdir+test
src/arr_pkg.sv
src/skew_bank.sv
src/act_feeder.sv
src/wt_feeder.sv
src/conv_sequencer.sv
src/arr_ctrl_top.sv
test/arr_ctrl_tb.sv

// ==== Makefile ====
TOP = arr_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== test/arr_model.svh ====
`ifndef ARR_MODEL_SVH
`define ARR_MODEL_SVH

// Reference rules for the lane values at the array edge
// Uses cfg_* and the memory copies held by the testbench

// Windows over one input plane
function automatic int conv_count();
    return (cfg_width - 2) * (cfg_height - 2);
endfunction

// Groups of LANES windows, rounded up
function automatic int group_count();
    return (conv_count() + arr_pkg::LANES - 1) / arr_pkg::LANES;
endfunction

// One step per channel and kernel position
function automatic int group_steps();
    return cfg_in_ch * arr_pkg::KSIZE * arr_pkg::KSIZE;
endfunction

// Real steps, then LANES-1 flush steps
function automatic int total_steps();
    return group_count() * group_steps() + arr_pkg::LANES - 1;
endfunction

// Weight on lane p at array step s
function automatic arr_pkg::byte_t exp_weight(input int s, input int p);
    int t;
    int c;
    int pos;
    int karea;
    karea = arr_pkg::KSIZE * arr_pkg::KSIZE;
    t = s - p;
    // Before the staircase reaches the lane, flush, or no output channel
    if (t < 0 || t >= group_count() * group_steps() || p >= cfg_out_ch) begin
        return 8'd0;
    end
    c = (t % group_steps()) / karea;
    // Kernel row and column together, row major
    pos = t % karea;
    return wt_mem[8'(p * karea * cfg_in_ch + karea * c + pos)];
endfunction

// Activation on lane p at array step s
function automatic arr_pkg::byte_t exp_act(input int s, input int p);
    int t;
    int g;
    int c;
    int r;
    int k;
    int n;
    int out_w;
    t = s - p;
    if (t < 0 || t >= group_count() * group_steps()) begin
        return 8'd0;
    end
    g = t / group_steps();
    c = (t % group_steps()) / (arr_pkg::KSIZE * arr_pkg::KSIZE);
    r = (t % (arr_pkg::KSIZE * arr_pkg::KSIZE)) / arr_pkg::KSIZE;
    k = t % arr_pkg::KSIZE;
    // Window index inside the group
    n = g * arr_pkg::LANES + p;
    if (n >= conv_count()) begin
        return 8'd0;
    end
    out_w = cfg_width - 2;
    return act_mem[8'(c * cfg_width * cfg_height + (n / out_w + r) * cfg_width
                      + n % out_w + k)];
endfunction

`endif

// ==== test/arr_ctrl_tb.sv ====
`timescale 1ns/100ps

module arr_ctrl_tb;

    // Entries in the vectors file are 4 config, 54 weights and 72 activations
    localparam int N_VEC       = 130;
    // 18 real steps plus 15 flush steps
    localparam int N_STEPS     = 33;
    // At most one idle cycle per byte plus two cycles per mode switch
    localparam int LOAD_CYCLES = 2 * N_VEC + 6;
    localparam int CYCLE_LIMIT = 2 * (LOAD_CYCLES + arr_pkg::LANES * N_STEPS);

    logic           clk;
    logic           rstn;
    logic           enable;
    arr_pkg::mode_t mode;
    logic           data_load;
    arr_pkg::byte_t data_in;
    arr_pkg::vec_t  aouts;
    arr_pkg::vec_t  wouts;
    logic           array_step;
    logic           fire;
    logic           done;

    // Raw stimulus and the model's memory copies
    arr_pkg::byte_t vec_mem [N_VEC];
    arr_pkg::byte_t wt_mem  [arr_pkg::MEM_DEPTH];
    arr_pkg::byte_t act_mem [arr_pkg::MEM_DEPTH];

    int cfg_out_ch;
    int cfg_in_ch;
    int cfg_width;
    int cfg_height;
    int n_wt;
    int n_act;

    int errors    = 0;
    int step_cnt  = 0;
    int cycles    = 0;
    int pauses    = 0;
    bit done_seen = 1'b0;
    bit step_prev = 1'b0;
    bit checking  = 1'b0;

    `include "arr_model.svh"

    arr_ctrl_top arr_ctrl_top_i (
        .clk        (clk),
        .rstn       (rstn),
        .enable     (enable),
        .mode       (mode),
        .data_load  (data_load),
        .data_in    (data_in),
        .aouts      (aouts),
        .wouts      (wouts),
        .array_step (array_step),
        .fire       (fire),
        .done       (done)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic report_value(input string sig, input int exp_v, input int got_v);
        $display("Fail at %0d ns: %s expected %0h got %0h", $time, sig, exp_v, got_v);
        errors++;
    endtask

    // Every lane of both outputs against the model
    task automatic check_lanes();
        arr_pkg::byte_t exp_a;
        arr_pkg::byte_t exp_w;
        for (int i = 0; i < arr_pkg::LANES; i++) begin
            exp_a = exp_act(step_cnt, i);
            exp_w = exp_weight(step_cnt, i);
            if (aouts[4'(i)] != exp_a) begin
                report_value($sformatf("aouts[%0d]", i), int'(exp_a), int'(aouts[4'(i)]));
            end
            if (wouts[4'(i)] != exp_w) begin
                report_value($sformatf("wouts[%0d]", i), int'(exp_w), int'(wouts[4'(i)]));
            end
        end
    endtask

    // Byte stream in one mode with random idle gaps
    task automatic load_bytes(input arr_pkg::mode_t m, input int first, input int count);
        @(posedge clk);
        mode      <= m;
        data_load <= 1'b0;
        for (int j = 0; j < count; j++) begin
            if ($urandom_range(3) == 0) begin
                @(posedge clk);
                data_load <= 1'b0;
            end
            @(posedge clk);
            data_load <= 1'b1;
            data_in   <= vec_mem[8'(first + j)];
        end
        @(posedge clk);
        data_load <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (checking) begin
            if (array_step) begin
                if (done_seen) begin
                    $display("Error at %0d ns: array step pulse after done", $time);
                    errors++;
                end
                check_lanes();
                step_cnt++;
            end
            // fire covers the whole compute run
            if (step_cnt > 0 && !done && !done_seen && !fire) begin
                report_value("fire", 1, 0);
            end
            if (done && fire) begin
                report_value("fire", 0, 1);
            end
            if (done && !done_seen) begin
                done_seen = 1'b1;
                if (!step_prev) begin
                    $display("Error at %0d ns: done rose without an array step before it",
                             $time);
                    errors++;
                end
                if (step_cnt != total_steps()) begin
                    report_value("array step count", total_steps(), step_cnt);
                end
            end
            // done holds while compute mode stays
            if (done_seen && !done && mode == arr_pkg::MODE_COMPUTE) begin
                report_value("done", 1, 0);
            end
            step_prev = array_step;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            errors++;
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Array steps: %0d, errors: %0d", step_cnt, errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        bit en_next;
        clk       = 1'b0;
        rstn      = 1'b0;
        enable    = 1'b0;
        mode      = arr_pkg::MODE_CONFIG;
        data_load = 1'b0;
        data_in   = 8'd0;
        void'($urandom(41));

        $readmemh("test/arr_vectors.txt", vec_mem);
        // Config order matches the load order
        cfg_out_ch = int'(vec_mem[0]);
        cfg_in_ch  = int'(vec_mem[1]);
        cfg_width  = int'(vec_mem[2]);
        cfg_height = int'(vec_mem[3]);
        n_wt  = cfg_out_ch * cfg_in_ch * arr_pkg::KSIZE * arr_pkg::KSIZE;
        n_act = cfg_in_ch * cfg_width * cfg_height;
        for (int i = 0; i < n_wt; i++) begin
            wt_mem[8'(i)] = vec_mem[8'(4 + i)];
        end
        for (int i = 0; i < n_act; i++) begin
            act_mem[8'(i)] = vec_mem[8'(4 + n_wt + i)];
        end

        repeat (2) @(posedge clk);
        rstn   <= 1'b1;
        enable <= 1'b1;

        // Quiet outputs straight after reset
        @(negedge clk);
        if (done) begin
            report_value("done", 0, 1);
        end
        if (fire) begin
            report_value("fire", 0, 1);
        end
        if (array_step) begin
            report_value("array_step", 0, 1);
        end
        for (int i = 0; i < arr_pkg::LANES; i++) begin
            if (aouts[4'(i)] != 8'd0) begin
                report_value($sformatf("aouts[%0d]", i), 0, int'(aouts[4'(i)]));
            end
            if (wouts[4'(i)] != 8'd0) begin
                report_value($sformatf("wouts[%0d]", i), 0, int'(wouts[4'(i)]));
            end
        end
        checking = 1'b1;

        load_bytes(arr_pkg::MODE_CONFIG, 0, 4);
        load_bytes(arr_pkg::MODE_WEIGHT, 4, n_wt);
        load_bytes(arr_pkg::MODE_DATA, 4 + n_wt, n_act);

        // Compute with random pauses on enable
        @(posedge clk);
        mode <= arr_pkg::MODE_COMPUTE;
        while (!done_seen) begin
            @(posedge clk);
            en_next = ($urandom_range(7) != 0);
            if (!en_next) begin
                pauses++;
            end
            enable <= en_next;
        end
        @(posedge clk);
        enable <= 1'b1;

        // Done must stay and no step may follow while compute mode holds
        repeat (20) @(posedge clk);
        mode <= arr_pkg::MODE_CONFIG;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (done) begin
            report_value("done", 0, 1);
        end
        if (fire) begin
            report_value("fire", 0, 1);
        end

        if (pauses == 0) begin
            $display("Error: no enable pause was inserted during compute");
            errors++;
        end
        if (step_cnt != N_STEPS) begin
            report_value("array step count", N_STEPS, step_cnt);
        end

        $display("Array steps: %0d, errors: %0d", step_cnt, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src/arr_ctrl_top.sv ====
`timescale 1ns/100ps

module arr_ctrl_top (
    input  logic           clk,
    input  logic           rstn,
    input  logic           enable,
    input  arr_pkg::mode_t mode,
    input  logic           data_load,
    input  arr_pkg::byte_t data_in,
    output arr_pkg::vec_t  aouts,
    output arr_pkg::vec_t  wouts,
    output logic           array_step,
    output logic           fire,
    output logic           done
);

    // Sequencer to feeders
    arr_pkg::cfg_t  cfg;
    logic           w_wr;
    logic           a_wr;
    arr_pkg::addr_t wr_addr;
    logic           issue;
    arr_pkg::lane_t lane;
    arr_pkg::byte_t chan;
    logic [1:0]     krow;
    logic [1:0]     kcol;
    logic [15:0]    conv_base;
    logic           flush;

    // Feeders to skew bank
    arr_pkg::vec_t  a_vec;
    logic           a_valid;
    arr_pkg::vec_t  w_vec;
    logic           w_valid;

    conv_sequencer conv_sequencer_i (
        .clk        (clk),
        .rstn       (rstn),
        .enable     (enable),
        .mode       (mode),
        .data_load  (data_load),
        .data_in    (data_in),
        .array_step (array_step),
        .cfg        (cfg),
        .w_wr       (w_wr),
        .a_wr       (a_wr),
        .wr_addr    (wr_addr),
        .issue      (issue),
        .lane       (lane),
        .chan       (chan),
        .krow       (krow),
        .kcol       (kcol),
        .conv_base  (conv_base),
        .flush      (flush),
        .fire       (fire),
        .done       (done)
    );

    act_feeder act_feeder_i (
        .clk       (clk),
        .rstn      (rstn),
        .data_in   (data_in),
        .a_wr      (a_wr),
        .wr_addr   (wr_addr),
        .cfg       (cfg),
        .issue     (issue),
        .lane      (lane),
        .chan      (chan),
        .krow      (krow),
        .kcol      (kcol),
        .conv_base (conv_base),
        .flush     (flush),
        .vector    (a_vec),
        .vec_valid (a_valid)
    );

    wt_feeder wt_feeder_i (
        .clk       (clk),
        .rstn      (rstn),
        .data_in   (data_in),
        .w_wr      (w_wr),
        .wr_addr   (wr_addr),
        .cfg       (cfg),
        .issue     (issue),
        .lane      (lane),
        .chan      (chan),
        .krow      (krow),
        .kcol      (kcol),
        .flush     (flush),
        .vector    (w_vec),
        .vec_valid (w_valid)
    );

    // Array edge sees a staircase of both vectors
    skew_bank #(
        .LANES (arr_pkg::LANES)
    ) skew_bank_i (
        .clk        (clk),
        .rstn       (rstn),
        .a_vec      (a_vec),
        .a_valid    (a_valid),
        .w_vec      (w_vec),
        .w_valid    (w_valid),
        .aouts      (aouts),
        .wouts      (wouts),
        .array_step (array_step)
    );

endmodule

// ==== src/conv_sequencer.sv ====
`timescale 1ns/100ps

module conv_sequencer (
    input  logic           clk,
    input  logic           rstn,
    input  logic           enable,
    input  arr_pkg::mode_t mode,
    input  logic           data_load,
    input  arr_pkg::byte_t data_in,
    input  logic           array_step,
    output arr_pkg::cfg_t  cfg,
    output logic           w_wr,
    output logic           a_wr,
    output arr_pkg::addr_t wr_addr,
    output logic           issue,
    output arr_pkg::lane_t lane,
    output arr_pkg::byte_t chan,
    output logic [1:0]     krow,
    output logic [1:0]     kcol,
    output logic [15:0]    conv_base,
    output logic           flush,
    output logic           fire,
    output logic           done
);

    localparam logic [1:0] KLAST     = 2'(arr_pkg::KSIZE - 1);
    localparam logic [3:0] LANE_LAST = 4'(arr_pkg::LANES - 1);
    // Flush runs LANES-1 steps
    localparam logic [3:0] FLUSH_LAST = 4'(arr_pkg::LANES - 2);

    arr_pkg::mode_t mode_q;
    arr_pkg::addr_t wr_cnt;
    logic           load;

    logic [15:0]    n_conv;
    logic           last_lane;
    logic           last_chan;
    logic           last_group;
    logic           last_item;
    logic           issue_nxt;
    logic           done_set;
    logic           all_issued;
    logic [3:0]     flush_cnt;
    logic [1:0]     pending;

    ////////////////////////////////////////
    // Config and memory loading
    ////////////////////////////////////////

    // A byte is taken only while enabled
    assign load = enable && data_load;
    assign w_wr = load && (mode == arr_pkg::MODE_WEIGHT);
    assign a_wr = load && (mode == arr_pkg::MODE_DATA);

    // Address restarts at zero on the first cycle of a new mode
    assign wr_addr = (mode != mode_q) ? 8'd0 : wr_cnt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mode_q <= arr_pkg::MODE_CONFIG;
            wr_cnt <= 8'd0;
            cfg    <= '0;
        end else begin
            mode_q <= mode;
            wr_cnt <= load ? wr_addr + 8'd1 : wr_addr;
            // Config bytes land in order and extras are ignored
            if (load && mode == arr_pkg::MODE_CONFIG && wr_addr < 8'd4) begin
                case (wr_addr[1:0])
                    2'd0:    cfg.out_ch <= data_in;
                    2'd1:    cfg.in_ch  <= data_in;
                    2'd2:    cfg.width  <= data_in;
                    default: cfg.height <= data_in;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Compute step counters
    ////////////////////////////////////////

    // Total windows over one input plane
    assign n_conv = {8'd0, cfg.width - 8'd2} * {8'd0, cfg.height - 8'd2};

    assign last_lane  = (lane == LANE_LAST);
    assign last_chan  = (chan == cfg.in_ch - 8'd1);
    assign last_group = (conv_base + 16'(arr_pkg::LANES) >= n_conv);

    // Lane 15 of the final flush step
    assign last_item = issue && flush && last_lane && (flush_cnt == FLUSH_LAST);

    // Keep issuing until the final flush lane goes out
    assign issue_nxt = enable && !all_issued && !last_item;

    // Final flush step leaves the skew bank
    assign done_set = all_issued && array_step && (pending == 2'd1);

    // Whole block clears when compute mode is left
    always_ff @(posedge clk) begin
        if (!rstn || mode != arr_pkg::MODE_COMPUTE) begin
            issue      <= 1'b0;
            lane       <= '0;
            chan       <= '0;
            krow       <= '0;
            kcol       <= '0;
            conv_base  <= '0;
            flush      <= 1'b0;
            flush_cnt  <= '0;
            all_issued <= 1'b0;
            pending    <= '0;
            fire       <= 1'b0;
            done       <= 1'b0;
        end else begin
            issue      <= issue_nxt;
            all_issued <= all_issued || last_item;
            // Steps pushed but not yet seen at the array
            pending <= pending + {1'b0, issue && last_lane} - {1'b0, array_step};

            if (done_set) begin
                done <= 1'b1;
                fire <= 1'b0;
            end else if (issue_nxt) begin
                fire <= 1'b1;
            end

            // Counters move past an item once it has gone out
            if (issue) begin
                lane <= lane + 4'd1;
                if (last_lane) begin
                    if (flush) begin
                        flush_cnt <= flush_cnt + 4'd1;
                    end else if (kcol != KLAST) begin
                        kcol <= kcol + 2'd1;
                    end else begin
                        kcol <= '0;
                        if (krow != KLAST) begin
                            krow <= krow + 2'd1;
                        end else begin
                            krow <= '0;
                            if (!last_chan) begin
                                chan <= chan + 8'd1;
                            end else begin
                                chan <= '0;
                                // Next group of 16 windows or drain
                                if (last_group) begin
                                    flush <= 1'b1;
                                end else begin
                                    conv_base <= conv_base + 16'(arr_pkg::LANES);
                                end
                            end
                        end
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // No item goes out while another mode is selected
    a_issue_mode: assert property (@(posedge clk) disable iff (!rstn)
        issue |-> mode == arr_pkg::MODE_COMPUTE);

    // Completion waits for the last issue
    a_done_quiet: assert property (@(posedge clk) disable iff (!rstn)
        done |-> !issue);

endmodule

// ==== src/wt_feeder.sv ====
`timescale 1ns/100ps

module wt_feeder (
    input  logic           clk,
    input  logic           rstn,
    input  arr_pkg::byte_t data_in,
    input  logic           w_wr,
    input  arr_pkg::addr_t wr_addr,
    input  arr_pkg::cfg_t  cfg,
    input  logic           issue,
    input  arr_pkg::lane_t lane,
    input  arr_pkg::byte_t chan,
    input  logic [1:0]     krow,
    input  logic [1:0]     kcol,
    input  logic           flush,
    output arr_pkg::vec_t  vector,
    output logic           vec_valid
);

    // Words in one 3x3 kernel slice
    localparam logic [15:0] KAREA = 16'(arr_pkg::KSIZE * arr_pkg::KSIZE);

    // One kernel per output channel, each in_ch slices deep
    arr_pkg::byte_t mem [arr_pkg::MEM_DEPTH];

    arr_pkg::addr_t addr;
    logic           pad;

    arr_pkg::byte_t rd_data;
    arr_pkg::lane_t lane_q;
    logic           pad_q;
    logic           issue_q;
    logic           last_q;

    // Lane picks the kernel, then channel slice and position
    assign addr = arr_pkg::addr_t'(16'(lane) * KAREA * 16'(cfg.in_ch)
                                   + KAREA * 16'(chan)
                                   + 16'(arr_pkg::KSIZE) * 16'(krow)
                                   + 16'(kcol));

    // Lanes with no output channel stay zero
    assign pad = flush || (8'(lane) >= cfg.out_ch);

    // Loads write, compute reads one byte per issue
    always_ff @(posedge clk) begin
        if (w_wr) begin
            mem[wr_addr] <= data_in;
        end
        if (issue) begin
            rd_data <= mem[addr];
            lane_q  <= lane;
            pad_q   <= pad;
        end
    end

    // Same two-stage latency as the activation side
    always_ff @(posedge clk) begin
        if (!rstn) begin
            issue_q   <= 1'b0;
            last_q    <= 1'b0;
            vector    <= '0;
            vec_valid <= 1'b0;
        end else begin
            issue_q   <= issue;
            last_q    <= issue && (lane == 4'(arr_pkg::LANES - 1));
            vec_valid <= last_q;
            if (issue_q) begin
                vector[lane_q] <= pad_q ? 8'd0 : rd_data;
            end
        end
    end

endmodule

// ==== src/act_feeder.sv ====
`timescale 1ns/100ps

module act_feeder (
    input  logic           clk,
    input  logic           rstn,
    input  arr_pkg::byte_t data_in,
    input  logic           a_wr,
    input  arr_pkg::addr_t wr_addr,
    input  arr_pkg::cfg_t  cfg,
    input  logic           issue,
    input  arr_pkg::lane_t lane,
    input  arr_pkg::byte_t chan,
    input  logic [1:0]     krow,
    input  logic [1:0]     kcol,
    input  logic [15:0]    conv_base,
    input  logic           flush,
    output arr_pkg::vec_t  vector,
    output logic           vec_valid
);

    // Activations stored channel plane by plane, row major
    arr_pkg::byte_t mem [arr_pkg::MEM_DEPTH];

    logic [15:0]    width16;
    logic [15:0]    height16;
    logic [15:0]    out_w;
    logic [15:0]    n_conv;
    logic [15:0]    n;
    logic [15:0]    x0;
    logic [15:0]    y0;
    arr_pkg::addr_t addr;
    logic           pad;

    arr_pkg::byte_t rd_data;
    arr_pkg::lane_t lane_q;
    logic           pad_q;
    logic           issue_q;
    logic           last_q;

    ////////////////////////////////////////
    // Window position and address
    ////////////////////////////////////////

    assign width16  = {8'd0, cfg.width};
    assign height16 = {8'd0, cfg.height};

    // Window origins per row and in total
    assign out_w  = width16 - 16'd2;
    assign n_conv = out_w * (height16 - 16'd2);

    // Lane p takes window n of the current group
    assign n  = conv_base + 16'(lane);
    assign x0 = n % out_w;
    assign y0 = n / out_w;

    // Channel plane, then kernel row, then kernel column
    assign addr = arr_pkg::addr_t'(16'(chan) * width16 * height16
                                   + (y0 + 16'(krow)) * width16
                                   + x0 + 16'(kcol));

    // No window behind this lane, or draining
    assign pad = flush || (n >= n_conv);

    ////////////////////////////////////////
    // Memory and lane vector
    ////////////////////////////////////////

    // Loads write, compute reads one byte per issue
    always_ff @(posedge clk) begin
        if (a_wr) begin
            mem[wr_addr] <= data_in;
        end
        if (issue) begin
            rd_data <= mem[addr];
            lane_q  <= lane;
            pad_q   <= pad;
        end
    end

    // Second stage drops the byte into its lane slot
    always_ff @(posedge clk) begin
        if (!rstn) begin
            issue_q   <= 1'b0;
            last_q    <= 1'b0;
            vector    <= '0;
            vec_valid <= 1'b0;
        end else begin
            issue_q   <= issue;
            last_q    <= issue && (lane == 4'(arr_pkg::LANES - 1));
            vec_valid <= last_q;
            if (issue_q) begin
                vector[lane_q] <= pad_q ? 8'd0 : rd_data;
            end
        end
    end

endmodule

// ==== src/skew_bank.sv ====
`timescale 1ns/100ps

module skew_bank #(
    parameter int LANES = 16
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  arr_pkg::byte_t [LANES-1:0]   a_vec,
    input  logic                         a_valid,
    input  arr_pkg::byte_t [LANES-1:0]   w_vec,
    input  logic                         w_valid,
    output arr_pkg::byte_t [LANES-1:0]   aouts,
    output arr_pkg::byte_t [LANES-1:0]   wouts,
    output logic                         array_step
);

    ////////////////////////////////////////
    // Triangular delay lines
    ////////////////////////////////////////

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        // Last stage of lane i holds the vector from i shifts back
        arr_pkg::byte_t a_pipe [0:i];
        arr_pkg::byte_t w_pipe [0:i];

        always_ff @(posedge clk) begin
            if (!rstn) begin
                for (int j = 0; j <= i; j++) begin
                    a_pipe[j] <= '0;
                    w_pipe[j] <= '0;
                end
            end else if (a_valid) begin
                a_pipe[0] <= a_vec[i];
                w_pipe[0] <= w_vec[i];
                for (int j = 1; j <= i; j++) begin
                    a_pipe[j] <= a_pipe[j-1];
                    w_pipe[j] <= w_pipe[j-1];
                end
            end
        end

        assign aouts[i] = a_pipe[i];
        assign wouts[i] = w_pipe[i];
    end

    // One array step per shift, aligned with the new outputs
    always_ff @(posedge clk) begin
        if (!rstn) begin
            array_step <= 1'b0;
        end else begin
            array_step <= a_valid;
        end
    end

    // Both feeders must finish each step together
    a_feed_align: assert property (@(posedge clk) disable iff (!rstn)
        a_valid == w_valid);

endmodule

// ==== src/arr_pkg.sv ====
package arr_pkg;

    // Array geometry and memory size
    localparam int LANES     = 16;
    localparam int MEM_DEPTH = 256;
    localparam int KSIZE     = 3;

    typedef logic [7:0] byte_t;
    typedef logic [7:0] addr_t;
    typedef logic [3:0] lane_t;

    // Operating modes as driven on the mode pins
    typedef enum logic [1:0] {
        MODE_CONFIG  = 2'd0,
        MODE_WEIGHT  = 2'd1,
        MODE_DATA    = 2'd2,
        MODE_COMPUTE = 2'd3
    } mode_t;

    // Convolution setup, loaded in this byte order
    typedef struct packed {
        byte_t out_ch;
        byte_t in_ch;
        byte_t width;
        byte_t height;
    } cfg_t;

    // One byte per array lane
    typedef byte_t [LANES-1:0] vec_t;

endpackage
